// File: logic/sram_tile_defines.svh
/*
 * sram tile geometry
 * word, address and macro widths shared by the tiled ram
 */
`ifndef SRAM_TILE_DEFINES_SVH
`define SRAM_TILE_DEFINES_SVH

`define SRAM_DW        32                              // data word width
`define SRAM_AW        11                              // word address width
`define SRAM_MACRO_AW  9                               // macro row address width
`define SRAM_MACRO_W   8                               // macro data width
`define SRAM_BE_W      (`SRAM_DW / 8)                  // one enable per byte
`define SRAM_BANKS     (1 << (`SRAM_AW - `SRAM_MACRO_AW)) // address banks
`define SRAM_DEPTH     (1 << `SRAM_AW)                 // words in the tile

`endif

// File: logic/sram_tile_pkg.sv
/*
 * sram tile types
 * vector types for words, masks and addresses, plus the clear fsm states
 */
`default_nettype none

`include "sram_tile_defines.svh"

package sram_tile_pkg;

    typedef logic [`SRAM_DW-1:0]                  data_t;  // data word
    typedef logic [`SRAM_DW-1:0]                  wmask_t; // per bit write mask
    typedef logic [`SRAM_BE_W-1:0]                be_t;    // byte enables
    typedef logic [`SRAM_AW-1:0]                  addr_t;  // word address
    typedef logic [`SRAM_MACRO_AW-1:0]            row_t;   // macro row
    typedef logic [`SRAM_AW-`SRAM_MACRO_AW-1:0]   bank_t;  // bank index
    typedef logic [`SRAM_MACRO_W-1:0]             lane_t;  // one macro's data or mask

    // clear sequencer
    typedef enum logic [1:0] {
        clr_idle_run, // cleared, serving requests
        clr_sweep,    // zeroing one row per cycle
        clr_done      // last write in flight
    } clr_state_t;

endpackage

`default_nettype wire

// File: logic/sram_port_if.sv
/*
 * internal memory port
 * single cycle access strobe from controller to bank array, read data back
 */
`timescale 1ns/1ps
`default_nettype none

interface sram_port_if
    import sram_tile_pkg::*;
(
    input logic clk
);

    logic   ce;    // access this cycle
    logic   we;    // write, else read
    addr_t  addr;  // word address
    wmask_t wmask; // bit mask, 1 writes
    data_t  din;   // write data
    data_t  dout;  // last read word

    modport ctrl (
        input  clk,
        output ce,
        output we,
        output addr,
        output wmask,
        output din,
        input  dout
    );

    modport mem (
        input  clk,
        input  ce,
        input  we,
        input  addr,
        input  wmask,
        input  din,
        output dout
    );

endinterface

`default_nettype wire

// File: logic/sram_macro_model.sv
/*
 * 512x8 sram macro model
 * behavioral stand-in for the hard macro, active low chip, global
 * and per bit write enables, registered q
 */
`timescale 1ns/1ps
`default_nettype none

`include "sram_tile_defines.svh"

module sram_macro_model
    import sram_tile_pkg::*;
(
    input  wire   clk,
    input  logic  cen,  // chip enable, low active
    input  logic  gwen, // global write enable, low active
    input  lane_t wen,  // bit write enables, low active
    input  row_t  a,    // row address
    input  lane_t d,    // write data
    output lane_t q     // read data
);

    localparam int ROWS = 1 << `SRAM_MACRO_AW;

    lane_t mem [ROWS];  // bit cells, no reset like the real array

    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!gwen) begin
                for (int i = 0; i < `SRAM_MACRO_W; i++) begin
                    if (!wen[i]) begin
                        mem[a][i] <= d[i]; // only unmasked bits
                    end
                end
            end else begin
                q <= mem[a]; // read updates q
            end
        end
        // q holds through writes and idle cycles
    end

endmodule

`default_nettype wire

// File: logic/sram_bank_array.sv
/*
 * sram bank array
 * tiles 512x8 macros into address banks and byte lanes, enables only the
 * addressed bank and returns the registered output of the last read bank
 */
`timescale 1ns/1ps
`default_nettype none

`include "sram_tile_defines.svh"

module sram_bank_array
    import sram_tile_pkg::*;
(
    input  wire       clk,
    sram_port_if.mem  port
);

    localparam int LW = `SRAM_MACRO_W;

    bank_t bank;                               // upper address bits
    row_t  row;                                // row inside each macro
    bank_t rd_bank;                            // bank of the last read
    lane_t bank_q [`SRAM_BANKS][`SRAM_BE_W];   // every macro's q
    data_t rd_word;                            // muxed read word

    assign bank = port.addr[`SRAM_AW-1:`SRAM_MACRO_AW];
    assign row  = port.addr[`SRAM_MACRO_AW-1:0];

    // remember which bank a read went to, writes keep the old select
    always_ff @(posedge clk) begin
        if (port.ce && !port.we) begin
            rd_bank <= bank;
        end
    end

    genvar b;
    genvar l;
    generate
        for (b = 0; b < `SRAM_BANKS; b++) begin : g_bank
            logic sel;       // this bank addressed
            logic bank_cen;  // low active chip enable
            logic bank_gwen; // low active write enable

            assign sel       = (bank == bank_t'(b));
            assign bank_cen  = ~(port.ce & sel);
            assign bank_gwen = ~(port.we & sel);

            for (l = 0; l < `SRAM_BE_W; l++) begin : g_lane
                lane_t lane_d;    // lane slice of din
                lane_t lane_wen;  // inverted lane mask

                assign lane_d   = port.din[l*LW +: LW];
                assign lane_wen = ~port.wmask[l*LW +: LW]; // macro wants 0 to write

                sram_macro_model u_macro (
                    .clk  (clk),
                    .cen  (bank_cen),
                    .gwen (bank_gwen),
                    .wen  (lane_wen),
                    .a    (row),
                    .d    (lane_d),
                    .q    (bank_q[b][l])
                );
            end
        end
    endgenerate

    // only the read bank reaches dout
    always_comb begin
        for (int i = 0; i < `SRAM_BE_W; i++) begin
            rd_word[i*LW +: LW] = bank_q[rd_bank][i];
        end
    end

    assign port.dout = rd_word;

endmodule

`default_nettype wire

// File: logic/sram_access_ctrl.sv
/*
 * sram access controller
 * zeroes the whole tile after reset, registers requests onto the memory port,
 * widens byte enables to bit masks and returns reads two cycles later
 */
`timescale 1ns/1ps
`default_nettype none

`include "sram_tile_defines.svh"

module sram_access_ctrl
    import sram_tile_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  logic       req,        // single cycle request strobe
    input  logic       req_write,  // write, else read
    input  addr_t      req_addr,
    input  data_t      req_wdata,
    input  be_t        req_be,     // byte enables for writes
    output logic       rsp_valid,  // one cycle per read
    output data_t      rsp_rdata,
    output logic       busy,       // clear in progress
    output logic       req_drop,   // request lost to the clear
    sram_port_if.ctrl  port
);

    localparam addr_t CLR_LAST = addr_t'(`SRAM_DEPTH - 1);
    localparam int    LW       = `SRAM_MACRO_W;

    clr_state_t clr_state;
    addr_t      clr_addr;   // next row to zero
    logic       clr_write;  // sweep write this cycle
    logic       accept;     // request goes to the port
    wmask_t     be_mask;    // byte enables widened to bits
    logic [1:0] rd_pipe;    // read flags, one per stage

    // first sweep cycle only raises busy, so busy spans depth plus one
    assign clr_write = (clr_state == clr_sweep) && busy;
    assign accept    = req && !busy && (clr_state == clr_idle_run);

    always_comb begin
        for (int i = 0; i < `SRAM_BE_W; i++) begin
            be_mask[i*LW +: LW] = {LW{req_be[i]}}; // whole byte or nothing
        end
    end

    // clear sequencer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clr_state <= clr_sweep;
            clr_addr  <= '0;
            busy      <= 1'b0;
        end else begin
            case (clr_state)
                clr_sweep: begin
                    busy <= 1'b1;                  // armed on the first edge
                    if (busy) begin
                        clr_addr <= clr_addr + 1'b1;
                        if (clr_addr == CLR_LAST) begin
                            clr_state <= clr_done; // last row issued
                        end
                    end
                end
                clr_done: begin
                    busy      <= 1'b0;             // last write landed
                    clr_state <= clr_idle_run;
                end
                default: begin
                    busy <= 1'b0;                  // serving requests
                end
            endcase
        end
    end

    // port strobe, read tracking and drop flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            port.ce   <= 1'b0;
            rd_pipe   <= '0;
            rsp_valid <= 1'b0;
            req_drop  <= 1'b0;
        end else begin
            port.ce   <= clr_write | accept;
            rd_pipe   <= {rd_pipe[0], accept & ~req_write}; // issue, then array
            rsp_valid <= rd_pipe[1];
            req_drop  <= req & ~accept;  // anything not taken is lost
        end
    end

    // port payload
    always_ff @(posedge clk) begin
        if (clr_write) begin
            port.we    <= 1'b1;
            port.addr  <= clr_addr;
            port.wmask <= '1;            // full word of zeros
            port.din   <= '0;
        end else begin
            port.we    <= req_write;
            port.addr  <= req_addr;
            port.wmask <= be_mask;
            port.din   <= req_wdata;
        end
    end

    // dout holds the word read one edge ago
    always_ff @(posedge clk) begin
        if (rd_pipe[1]) begin
            rsp_rdata <= port.dout;
        end
    end

endmodule

`default_nettype wire

// File: logic/sram_tile_top.sv
/*
 * sram tile top
 * access controller in front of the tiled macro bank array
 */
`timescale 1ns/1ps
`default_nettype none

module sram_tile_top
    import sram_tile_pkg::*;
(
    input  wire    clk,
    input  wire    rst_n,
    input  logic   req,
    input  logic   req_write,
    input  addr_t  req_addr,
    input  data_t  req_wdata,
    input  be_t    req_be,
    output logic   rsp_valid,
    output data_t  rsp_rdata,
    output logic   busy,
    output logic   req_drop
);

    sram_port_if port_if (.clk(clk)); // controller to array

    sram_access_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_be    (req_be),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .busy      (busy),
        .req_drop  (req_drop),
        .port      (port_if.ctrl)
    );

    sram_bank_array u_array (
        .clk  (clk),
        .port (port_if.mem)
    );

endmodule

`default_nettype wire

// File: bench/sram_tile_tb.sv
/*
 * sram tile testbench
 * lfsr driven requests against a word model of the tile, checks the
 * power-up clear, read latency, byte writes, pipelined traffic and drops
 */
`timescale 1ns/1ps
`default_nettype none

`include "sram_tile_defines.svh"

module sram_tile_tb
    import sram_tile_pkg::*;
();

    localparam int DEPTH       = `SRAM_DEPTH;
    localparam int N_CLR_READS = 16;
    localparam int N_FULL      = 16;
    localparam int N_PART      = 12;
    localparam int N_MIX       = 200;
    localparam int N_DROP      = 8;
    localparam int DROP_WAIT   = 100;            // sweep well past the low rows
    localparam int DROP_AW     = 5;              // drop targets in rows 0..31
    localparam int CLEAR_CYC   = DEPTH + 1 + 4;  // sweep plus reset and slack
    localparam int TEST_CYC    = 4 * (N_CLR_READS + 2) + 4 * N_FULL + 6 * N_PART
                                 + 2 * N_MIX + DROP_WAIT + 4 * N_DROP + 100;
    localparam int TIMEOUT_CYC = 3 * (2 * CLEAR_CYC + TEST_CYC); // two clears

    logic  clk;
    logic  rst_n;
    logic  req;
    logic  req_write;
    addr_t req_addr;
    data_t req_wdata;
    be_t   req_be;
    logic  rsp_valid;
    data_t rsp_rdata;
    logic  busy;
    logic  req_drop;

    data_t       model [DEPTH];  // expected memory contents
    data_t       data_q[$];      // expected read words, in issue order
    int          due_q[$];       // cycle each response must show up
    logic [31:0] lfsr_state = 32'h3d53_d9fc;
    int          cyc = 0;        // posedge counter
    int          checks = 0;
    int          errors = 0;
    int          rsp_count = 0;  // rsp_valid pulses seen
    int          drop_count = 0; // req_drop pulses seen
    logic        drop_pending = 1'b0;

    sram_tile_top sram_tile_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_be    (req_be),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .busy      (busy),
        .req_drop  (req_drop)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 100 MHz
    end

    // right shift galois, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state); // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // byte lanes with a set enable take the new data
    function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
        data_t r;
        r = old;
        for (int i = 0; i < `SRAM_BE_W; i++) begin
            if (be[i]) begin
                r[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // sees pre-edge values, same as the dut
    always @(posedge clk) begin : response_monitor
        logic exp_valid;
        if (!rst_n) begin
            drop_pending = 1'b0;
        end else begin
            check_value("req_drop", req_drop, drop_pending);
            exp_valid = (due_q.size() != 0) && (due_q[0] == cyc);
            check_value("rsp_valid", rsp_valid, exp_valid);
            if (rsp_valid) rsp_count++;
            if (req_drop) drop_count++;
            if (exp_valid) begin
                if (rsp_valid) check_value("rsp_rdata", rsp_rdata, data_q[0]);
                void'(data_q.pop_front());
                void'(due_q.pop_front());
            end
            drop_pending = req && busy;             // lost to the clear
            if (req && !busy) begin
                if (req_write) begin
                    model[req_addr] = merge_bytes(model[req_addr], req_wdata, req_be);
                end else begin
                    data_q.push_back(model[req_addr]); // value at issue time
                    due_q.push_back(cyc + 3);          // registered two edges later
                end
            end
        end
        cyc++;
    end

    initial begin : watchdog
        while (cyc < TIMEOUT_CYC) @(posedge clk);
        $display("run timed out after %0d cycles", cyc);
        $display("Verification failed");
        $finish;
    end

    task automatic apply_reset;
        @(posedge clk);
        rst_n <= 1'b0;
        req   <= 1'b0;
        repeat (2) @(posedge clk);
        for (int i = 0; i < DEPTH; i++) model[i] = '0; // tile is zero after the clear
        data_q.delete();
        due_q.delete();
        rst_n <= 1'b1;
    endtask

    // counts negedges with busy high until it drops again
    task automatic wait_clear(output int busy_len);
        bit seen;
        int n;
        seen     = 1'b0;
        busy_len = 0;
        n        = 0;
        while (!(seen && !busy) && n < 2 * DEPTH) begin
            @(negedge clk);
            n++;
            if (busy) begin
                seen = 1'b1;
                busy_len++;
            end
        end
    endtask

    task automatic send_req(input logic write, input addr_t addr, input data_t data,
                            input be_t be);
        @(posedge clk);
        req       <= 1'b1;
        req_write <= write;
        req_addr  <= addr;
        req_wdata <= data;
        req_be    <= be;
    endtask

    task automatic drain_reads;
        @(posedge clk);
        req <= 1'b0;
        @(posedge clk);                            // last request now logged
        while (due_q.size() != 0) @(posedge clk);
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s finished, %0d errors", name, errors - errs_before);
    endtask

    initial begin : main
        int    e0;
        int    blen;
        int    n_rd;
        int    rsp0;
        int    drop0;
        logic  prev_wr;
        addr_t prev_addr;
        addr_t addr;
        addr_t addrs [N_MIX];
        logic  wr;

        rst_n     = 1'b0;
        req       = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_be    = '0;

        // power-up clear and zero readback
        e0 = errors;
        apply_reset();
        wait_clear(blen);
        check_value("busy cycles", blen, DEPTH + 1);
        send_req(1'b0, addr_t'(0), '0, '0);
        send_req(1'b0, addr_t'(DEPTH - 1), '0, '0);
        for (int i = 0; i < N_CLR_READS; i++) begin
            send_req(1'b0, addr_t'(rand_bits(`SRAM_AW)), '0, '0);
        end
        drain_reads();
        report_test("clear", e0);

        // full words across all four banks
        e0 = errors;
        for (int i = 0; i < N_FULL; i++) begin
            addrs[i] = {bank_t'(i % `SRAM_BANKS), row_t'(rand_bits(`SRAM_MACRO_AW))};
            send_req(1'b1, addrs[i], data_t'(rand_bits(32)), 4'hf);
        end
        for (int i = 0; i < N_FULL; i++) send_req(1'b0, addrs[i], '0, '0);
        drain_reads();
        report_test("full_word", e0);

        // byte enables over known words
        e0 = errors;
        for (int i = 0; i < N_PART; i++) begin
            addrs[i] = addr_t'(rand_bits(`SRAM_AW));
            send_req(1'b1, addrs[i], data_t'(rand_bits(32)), 4'hf);
            send_req(1'b1, addrs[i], data_t'(rand_bits(32)), be_t'(rand_bits(4)));
        end
        for (int i = 0; i < N_PART; i++) send_req(1'b0, addrs[i], '0, '0);
        drain_reads();
        report_test("byte_enable", e0);

        // one request per cycle on a small address pool so hits repeat
        e0        = errors;
        rsp0      = rsp_count;
        n_rd      = 0;
        prev_wr   = 1'b0;
        prev_addr = '0;
        for (int i = 0; i < N_MIX; i++) begin
            if (prev_wr && rand_bits(1)) begin
                wr   = 1'b0;      // read straight after the write
                addr = prev_addr;
            end else begin
                wr   = rand_bits(1);
                addr = {bank_t'(rand_bits(2)), 6'd0, 3'(rand_bits(3))};
            end
            if (!wr) n_rd++;
            send_req(wr, addr, data_t'(rand_bits(32)), be_t'(rand_bits(4)));
            prev_wr   = wr;
            prev_addr = addr;
        end
        drain_reads();
        check_value("rsp_valid count", rsp_count - rsp0, n_rd);
        report_test("mixed_traffic", e0);

        // requests while the second clear runs, aimed at rows already zeroed
        e0 = errors;
        apply_reset();
        repeat (DROP_WAIT) @(posedge clk);         // sweep is past rows 0..31
        rsp0  = rsp_count;
        drop0 = drop_count;
        for (int i = 0; i < N_DROP; i++) begin
            addrs[i] = addr_t'(rand_bits(DROP_AW)); // a leaked write would stick here
            send_req(rand_bits(1), addrs[i], data_t'(rand_bits(32)), 4'hf);
        end
        @(posedge clk);
        req <= 1'b0;
        wait_clear(blen);
        check_value("req_drop count", drop_count - drop0, N_DROP);
        check_value("rsp_valid count", rsp_count - rsp0, 0);
        for (int i = 0; i < N_DROP; i++) send_req(1'b0, addrs[i], '0, '0);
        drain_reads();
        report_test("drop_during_clear", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sram_tile.f
+incdir+logic
logic/sram_tile_pkg.sv
logic/sram_port_if.sv
logic/sram_macro_model.sv
logic/sram_bank_array.sv
logic/sram_access_ctrl.sv
logic/sram_tile_top.sv
bench/sram_tile_tb.sv
